// File: hdmi_top.f
src/hdmi_pkg.sv
src/apb_reg_decode.sv
src/tx_init_seq.sv
src/i2c_byte_master.sv
src/video_timing.sv
src/pattern_out.sv
src/hdmi_top.sv
sim/tb_clk_gen.sv
sim/tx_chip_model.sv
sim/hdmi_top_tb.sv

// File: sim/hdmi_top_tb.sv
`timescale 1ns/1ps
module hdmi_top_tb;

  localparam int H_ACTIVE = 32;
  localparam int H_FRONT  = 4;
  localparam int H_SYNC   = 4;
  localparam int H_BACK   = 4;
  localparam int V_ACTIVE = 4;
  localparam int V_FRONT  = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 1;
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam logic [6:0] DEV_ADDR = 7'h39;

  logic        cfg_clk;
  logic        arst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        hd_scl;
  logic        hd_sda_oe;
  logic        init_over;
  logic        hs_out;
  logic        vs_out;
  logic        de_out;
  logic [7:0]  r_out;
  logic [7:0]  g_out;
  logic [7:0]  b_out;
  logic        model_pull;
  wire         sda_line = ~(hd_sda_oe | model_pull);  // pull-up on the bus
  int          nack_at;

  int                 n_checks;
  int                 n_err;
  int                 n_tests;
  int                 test_err_base;
  string              test_name;
  logic [31:0]        lcg_state;
  logic               mon_en;       // video monitor on
  hdmi_pkg::pattern_e cur_pat;
  int                 cyc;
  int                 de_run;
  int                 hs_run;
  int                 hs_last;
  int                 line_cnt;
  int                 frames_seen;
  logic               vs_prev;

  tb_clk_gen #(.PERIOD(10.0), .RST_CYCLES(8)) clk_gen (.cfg_clk, .arst_n);

  hdmi_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .I2C_DIV(2), .DEV_ADDR(DEV_ADDR)
  ) uut (
    .cfg_clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .hd_scl, .hd_sda_oe,
    .hd_sda_in (sda_line),
    .init_over, .hs_out, .vs_out, .de_out, .r_out, .g_out, .b_out
  );

  tx_chip_model model (.scl(hd_scl), .sda(sda_line), .nack_at, .sda_pull(model_pull));

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (act === exp)
    else
    begin
      n_err++;
      $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    end
  endtask

  task automatic abort_timeout(input string what);
    n_err++;
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = n_err;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s done, %0d errors", test_name, n_err - test_err_base);
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // bar order white, yellow, cyan, green, magenta, red, blue, black
  function automatic logic [15:0] bar_565(input int idx);
    logic [15:0] red;
    logic [15:0] grn;
    logic [15:0] blu;
    red = 16'hf800;
    grn = 16'h07e0;
    blu = 16'h001f;
    case (idx)
      0:       return red | grn | blu;
      1:       return red | grn;
      2:       return grn | blu;
      3:       return grn;
      4:       return red | blu;
      5:       return red;
      6:       return blu;
      default: return 16'h0000;
    endcase
  endfunction

  // expected rgb565 straight from the pattern rules
  function automatic logic [15:0] expected_565(input hdmi_pkg::pattern_e p, input int x,
                                               input int y);
    logic [4:0] red5;
    logic [5:0] grn6;
    red5 = 5'(x % 32);
    grn6 = 6'(y % 64);
    case (p)
      hdmi_pkg::PAT_BARS:  return bar_565((x * 8) / H_ACTIVE);
      hdmi_pkg::PAT_WHITE: return 16'hffff;
      hdmi_pkg::PAT_BLACK: return 16'h0000;
      default:             return {red5, grn6, 5'b00000};
    endcase
  endfunction

  task automatic check_pixel(input int x, input int y);
    logic [15:0] c;
    c = expected_565(cur_pat, x, y);
    expect_eq("r_out", {24'd0, c[15:11], 3'b000}, r_out);
    expect_eq("g_out", {24'd0, c[10:5], 2'b00}, g_out);
    expect_eq("b_out", {24'd0, c[4:0], 3'b000}, b_out);
  endtask

  // apb, setup then access, sampled before the bus is released
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    @(negedge cfg_clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge cfg_clk);
    penable = 1'b1;
    @(negedge cfg_clk);
    expect_eq("pslverr", exp_err, pslverr);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
    @(negedge cfg_clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge cfg_clk);
    penable = 1'b1;
    @(negedge cfg_clk);
    data = prdata;
    expect_eq("pslverr", exp_err, pslverr);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_init_done();
    logic [31:0] st;
    int n;
    st = 32'h1;
    n  = 0;
    while (st[0] && n < 2000)
    begin
      apb_read(hdmi_pkg::REG_STATUS, st, 1'b0);
      n++;
    end
    if (st[0])
      abort_timeout("init_busy to fall");
  endtask

  task automatic check_log(input int n);
    expect_eq("log count", n, model.log_cnt);
    for (int i = 0; i < n; i++)
    begin
      expect_eq("log dev addr", {DEV_ADDR, 1'b0}, model.log_dev[i]);
      expect_eq("log reg addr", hdmi_pkg::INIT_TABLE[i].reg_addr, model.log_reg[i]);
      expect_eq("log data", hdmi_pkg::INIT_TABLE[i].data, model.log_data[i]);
    end
  endtask

  // syncs drop one register stage after the ctrl write
  task automatic check_video_low();
    @(negedge cfg_clk);
    expect_eq("hs_out", 0, hs_out);
    expect_eq("vs_out", 0, vs_out);
    expect_eq("de_out", 0, de_out);
  endtask

  // monitor state changes on the rising edge, monitor runs on the falling one
  task automatic set_monitor(input hdmi_pkg::pattern_e p, input logic on);
    @(posedge cfg_clk);
    cur_pat = p;
    mon_en  = on;
  endtask

  task automatic wait_frames(input int n);
    int t;
    t = 0;
    @(posedge cfg_clk);
    while (frames_seen < n && t < 4000)
    begin
      @(posedge cfg_clk);
      t++;
    end
    if (frames_seen < n)
      abort_timeout("video frames");
  endtask

  task automatic run_video(input hdmi_pkg::pattern_e p);
    apb_write(hdmi_pkg::REG_CTRL, {28'd0, p, 2'b00}, 1'b0);  // pattern staged, video off
    check_video_low();
    set_monitor(p, 1'b1);
    apb_write(hdmi_pkg::REG_CTRL, {28'd0, p, 2'b10}, 1'b0);
    wait_frames(2);
    set_monitor(p, 1'b0);
  endtask

  // video checker, outputs settle after the rising edge
  always @(negedge cfg_clk)
  begin
    cyc++;
    expect_eq("pready", 1, pready);
    if (!de_out)
      expect_eq("rgb", 0, {r_out, g_out, b_out});  // black in blanking
    if (!mon_en)
    begin
      de_run      = 0;
      hs_run      = 0;
      hs_last     = -1;
      line_cnt    = 0;
      frames_seen = 0;
    end
    else
    begin
      if (de_out)
      begin
        check_pixel(de_run, line_cnt);
        de_run++;
      end
      else if (de_run != 0)
      begin
        expect_eq("de_out burst", H_ACTIVE, de_run);
        de_run = 0;
        line_cnt++;
      end
      if (hs_out)
      begin
        if (hs_run == 0)
        begin
          if (hs_last >= 0)
            expect_eq("hs_out period", H_TOTAL, cyc - hs_last);
          hs_last = cyc;
        end
        hs_run++;
      end
      else if (hs_run != 0)
      begin
        expect_eq("hs_out width", H_SYNC, hs_run);
        hs_run = 0;
      end
      if (vs_out && !vs_prev)  // frame boundary
      begin
        expect_eq("active lines", V_ACTIVE, line_cnt);
        line_cnt = 0;
        frames_seen++;
      end
    end
    vs_prev = vs_out;
  end

  initial
  begin : stimulus
    logic [31:0] rd;
    logic [31:0] v;
    logic [31:0] wv;
    int          n;
    int          start_pat;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    nack_at   = -1;
    mon_en    = 1'b0;
    cur_pat   = hdmi_pkg::PAT_BARS;
    vs_prev   = 1'b0;
    cyc       = 0;
    n_checks  = 0;
    n_err     = 0;
    n_tests   = 0;
    lcg_state = 32'd72501;
    n = 0;
    while (arst_n !== 1'b1 && n < 100)
    begin
      @(posedge cfg_clk);
      n++;
    end
    if (arst_n !== 1'b1)
      abort_timeout("reset release");

    start_test("reset and decode");
    @(negedge cfg_clk);
    expect_eq("hs_out", 0, hs_out);
    expect_eq("vs_out", 0, vs_out);
    expect_eq("de_out", 0, de_out);
    expect_eq("init_over", 0, init_over);
    expect_eq("hd_sda_oe", 0, hd_sda_oe);
    expect_eq("hd_scl", 1, hd_scl);
    apb_read(hdmi_pkg::REG_STATUS, rd, 1'b0);
    expect_eq("status", 0, rd);
    apb_read(8'h10, rd, 1'b1);  // unmapped
    expect_eq("prdata", 0, rd);
    apb_write(8'h08, 32'h0000_000e, 1'b1);
    apb_read(hdmi_pkg::REG_CTRL, rd, 1'b0);
    expect_eq("ctrl", 0, rd);  // untouched by the bad write
    end_test();

    start_test("register readback");
    for (int i = 0; i < 8; i++)
    begin
      v  = next_rand();
      wv = {28'd0, v[17:16], v[15], 1'b0};  // pattern, video_en
      apb_write(hdmi_pkg::REG_CTRL, wv, 1'b0);
      apb_read(hdmi_pkg::REG_CTRL, rd, 1'b0);
      expect_eq("ctrl", wv, rd);
    end
    apb_write(hdmi_pkg::REG_CTRL, 32'd0, 1'b0);
    end_test();

    start_test("initialization");
    model.clear_log();
    apb_write(hdmi_pkg::REG_CTRL, 32'h1, 1'b0);
    rd = 32'd0;
    n  = 0;
    while (!rd[0] && n < 4)  // busy within a few cycles
    begin
      apb_read(hdmi_pkg::REG_STATUS, rd, 1'b0);
      n++;
    end
    expect_eq("init_busy", 1, rd[0]);
    apb_read(hdmi_pkg::REG_CTRL, rd, 1'b0);
    expect_eq("init_start", 0, rd[0]);
    wait_init_done();
    apb_read(hdmi_pkg::REG_STATUS, rd, 1'b0);
    expect_eq("status", 32'h2, rd);
    expect_eq("init_over", 1, init_over);
    check_log(hdmi_pkg::INIT_LEN);
    end_test();

    start_test("nack handling");
    model.clear_log();
    nack_at = 2 * 3 + 2;  // data byte of entry 2
    apb_write(hdmi_pkg::REG_CTRL, 32'h1, 1'b0);
    wait_init_done();
    apb_read(hdmi_pkg::REG_STATUS, rd, 1'b0);
    expect_eq("status", 32'h4, rd);
    expect_eq("init_over", 0, init_over);
    check_log(2);
    apb_write(hdmi_pkg::REG_CTRL, 32'h2, 1'b0);  // video_en without a clean init
    repeat (3 * H_TOTAL)
    begin
      @(negedge cfg_clk);
      expect_eq("hs_out", 0, hs_out);
      expect_eq("vs_out", 0, vs_out);
      expect_eq("de_out", 0, de_out);
    end
    model.clear_log();
    nack_at = -1;
    apb_write(hdmi_pkg::REG_CTRL, 32'h1, 1'b0);
    wait_init_done();
    apb_read(hdmi_pkg::REG_STATUS, rd, 1'b0);
    expect_eq("status", 32'h2, rd);
    check_log(hdmi_pkg::INIT_LEN);
    end_test();

    start_test("video timing");
    run_video(hdmi_pkg::PAT_BARS);
    apb_write(hdmi_pkg::REG_CTRL, 32'd0, 1'b0);
    check_video_low();
    end_test();

    start_test("patterns");
    v         = next_rand();
    start_pat = int'(v[21:20]);
    for (int i = 0; i < 4; i++)
      run_video(hdmi_pkg::pattern_e'((start_pat + i) % 4));
    apb_write(hdmi_pkg::REG_CTRL, 32'd0, 1'b0);
    check_video_low();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_err);
    if (n_err == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps
module tb_clk_gen #(
  parameter real PERIOD     = 10.0,
  parameter int  RST_CYCLES = 8
) (
  output logic cfg_clk,
  output logic arst_n
);

  initial
  begin
    cfg_clk = 1'b0;
    forever #(PERIOD / 2.0) cfg_clk = ~cfg_clk;
  end

  // reset released on a falling edge, like the rest of the stimulus
  initial
  begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge cfg_clk);
    @(negedge cfg_clk);
    arst_n = 1'b1;
  end

endmodule

// File: sim/tx_chip_model.sv
`timescale 1ns/1ps
module tx_chip_model (
  input  logic scl,
  input  logic sda,       // resolved bus level
  input  int   nack_at,   // byte index to refuse, -1 for none
  output logic sda_pull   // 1 pulls the line low
);

  logic [7:0] shreg;
  logic [7:0] bytes [3];    // dev addr, reg, data
  logic [7:0] log_dev [16];
  logic [7:0] log_reg [16];
  logic [7:0] log_data [16];
  int         log_cnt;
  int         bit_cnt;
  int         txn_bytes;    // bytes in this transfer
  int         byte_total;   // bytes since last clear
  logic       in_txn;
  logic       acking;
  logic       refused;

  initial
  begin
    sda_pull   = 1'b0;
    in_txn     = 1'b0;
    acking     = 1'b0;
    refused    = 1'b0;
    bit_cnt    = 0;
    txn_bytes  = 0;
    byte_total = 0;
    log_cnt    = 0;
  end

  task automatic clear_log();
    log_cnt    = 0;
    byte_total = 0;
  endtask

  // start: sda falls with scl high
  always @(negedge sda)
  begin
    if (scl === 1'b1)
    begin
      in_txn    = 1'b1;
      bit_cnt   = 0;
      txn_bytes = 0;
      acking    = 1'b0;
      refused   = 1'b0;
    end
  end

  // stop: sda rises with scl high, log complete writes only
  always @(posedge sda)
  begin
    if (scl === 1'b1 && in_txn)
    begin
      in_txn = 1'b0;
      if (txn_bytes == 3 && !refused && log_cnt < 16)
      begin
        log_dev[log_cnt]  = bytes[0];
        log_reg[log_cnt]  = bytes[1];
        log_data[log_cnt] = bytes[2];
        log_cnt++;
      end
    end
  end

  always @(posedge scl)
  begin
    if (in_txn && !acking && bit_cnt < 8)
    begin
      shreg = {shreg[6:0], sda};  // msb first
      bit_cnt++;
    end
  end

  // ack slot opens after the 8th falling edge, closes on the 9th
  always @(negedge scl)
  begin
    if (in_txn)
    begin
      if (acking)
      begin
        sda_pull = 1'b0;
        acking   = 1'b0;
        bit_cnt  = 0;
      end
      else if (bit_cnt == 8)
      begin
        if (txn_bytes < 3)
          bytes[txn_bytes] = shreg;
        refused  = (byte_total == nack_at);
        sda_pull = !refused;  // released line reads as nack
        acking   = 1'b1;
        txn_bytes++;
        byte_total++;
      end
    end
  end

endmodule

// File: src/apb_reg_decode.sv
`timescale 1ns/1ps
module apb_reg_decode (
  input  logic                            cfg_clk,
  input  logic                            arst_n,
  input  logic [hdmi_pkg::APB_AW-1:0]     paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [hdmi_pkg::APB_DW-1:0]     pwdata,
  input  hdmi_pkg::status_t               status,
  output logic [hdmi_pkg::APB_DW-1:0]     prdata,
  output logic                            pready,
  output logic                            pslverr,
  output hdmi_pkg::ctrl_t                 ctrl
);

  logic               hit_ctrl;
  logic               hit_stat;
  logic               access;    // apb access phase
  logic               wr_ctrl;
  logic               start_q;   // init_start pulse
  logic               video_en_q;
  hdmi_pkg::pattern_e pattern_q;

  assign hit_ctrl = (paddr == hdmi_pkg::REG_CTRL);
  assign hit_stat = (paddr == hdmi_pkg::REG_STATUS);
  assign access   = psel & penable;
  assign wr_ctrl  = access & pwrite & hit_ctrl;  // status writes dropped

  assign pready  = 1'b1;                            // zero wait states
  assign pslverr = access & ~(hit_ctrl | hit_stat);

  // read mux, zero for unmapped
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      if (hit_ctrl)
        prdata[3:1] = {pattern_q, video_en_q};  // bit 0 always reads 0
      else if (hit_stat)
        prdata[2:0] = status;
    end
  end

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      start_q    <= 1'b0;
      video_en_q <= 1'b0;
      pattern_q  <= hdmi_pkg::PAT_BARS;
    end
    else
    begin
      start_q <= wr_ctrl & pwdata[0];  // self clearing
      if (wr_ctrl)
      begin
        video_en_q <= pwdata[1];
        pattern_q  <= hdmi_pkg::pattern_e'(pwdata[3:2]);
      end
    end
  end

  assign ctrl = '{pattern: pattern_q, video_en: video_en_q, init_start: start_q};

endmodule

// File: src/hdmi_pkg.sv
package hdmi_pkg;

  // bus and coordinate widths
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;
  localparam int PIX_W  = 12;  // pix_x / pix_y width

  // apb word addresses
  localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
  localparam logic [APB_AW-1:0] REG_STATUS = 8'h04;

  typedef enum logic [1:0] {
    PAT_BARS  = 2'd0,
    PAT_WHITE = 2'd1,
    PAT_BLACK = 2'd2,
    PAT_RAMP  = 2'd3
  } pattern_e;

  // ctrl register, bit 0 is the lsb
  typedef struct packed {
    pattern_e pattern;     // [3:2]
    logic     video_en;    // [1]
    logic     init_start;  // [0] pulse
  } ctrl_t;

  typedef struct packed {
    logic nack_err;   // [2]
    logic init_over;  // [1]
    logic init_busy;  // [0]
  } status_t;

  typedef struct packed {
    logic [7:0] reg_addr;
    logic [7:0] data;
  } i2c_req_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic de;
  } vid_sync_t;

  // transmitter bring-up, written in this order
  localparam int INIT_LEN = 6;
  localparam i2c_req_t INIT_TABLE [INIT_LEN] = '{
    '{8'h04, 8'h01},  // soft reset release
    '{8'h09, 8'h00},  // input select
    '{8'h1a, 8'h0c},  // rgb888 input format
    '{8'h30, 8'h55},  // tmds drive
    '{8'h41, 8'h21},  // hdmi mode
    '{8'h08, 8'h01}   // output on
  };

  // rgb565 bar colours, left to right
  localparam logic [15:0] BAR_COLORS [8] = '{
    16'hffff, 16'hffe0, 16'h07ff, 16'h07e0,
    16'hf81f, 16'hf800, 16'h001f, 16'h0000
  };

endpackage

// File: src/hdmi_top.sv
`timescale 1ns/1ps
module hdmi_top #(
  parameter int         H_ACTIVE = 640,
  parameter int         H_FRONT  = 16,
  parameter int         H_SYNC   = 96,
  parameter int         H_BACK   = 48,
  parameter int         V_ACTIVE = 480,
  parameter int         V_FRONT  = 10,
  parameter int         V_SYNC   = 2,
  parameter int         V_BACK   = 33,
  parameter int         I2C_DIV  = 25,
  parameter logic [6:0] DEV_ADDR = 7'h59
) (
  input  logic                         cfg_clk,
  input  logic                         arst_n,
  input  logic [hdmi_pkg::APB_AW-1:0]  paddr,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [hdmi_pkg::APB_DW-1:0]  pwdata,
  output logic [hdmi_pkg::APB_DW-1:0]  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         hd_scl,
  output logic                         hd_sda_oe,   // open drain, 1 pulls low
  input  logic                         hd_sda_in,
  output logic                         init_over,   // status light
  output logic                         hs_out,
  output logic                         vs_out,
  output logic                         de_out,
  output logic [7:0]                   r_out,
  output logic [7:0]                   g_out,
  output logic [7:0]                   b_out
);

  hdmi_pkg::ctrl_t             ctrl;
  hdmi_pkg::status_t           status;
  hdmi_pkg::i2c_req_t          req;
  hdmi_pkg::vid_sync_t         sync;
  logic                        req_valid;
  logic                        done;
  logic                        nack;
  logic                        video_on;
  logic [hdmi_pkg::PIX_W-1:0]  pix_x;
  logic [hdmi_pkg::PIX_W-1:0]  pix_y;

  assign init_over = status.init_over;

  apb_reg_decode u_apb (
    .cfg_clk, .arst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
    .status, .prdata, .pready, .pslverr, .ctrl
  );

  tx_init_seq u_seq (
    .cfg_clk, .arst_n, .ctrl, .done, .nack,
    .req_valid, .req, .status, .video_on
  );

  i2c_byte_master #(.I2C_DIV(I2C_DIV), .DEV_ADDR(DEV_ADDR)) u_i2c (
    .cfg_clk, .arst_n, .req_valid, .req,
    .sda_in (hd_sda_in),
    .scl    (hd_scl),
    .sda_oe (hd_sda_oe),
    .done, .nack
  );

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .cfg_clk, .arst_n, .video_on, .sync, .pix_x, .pix_y
  );

  pattern_out #(.H_ACTIVE(H_ACTIVE)) u_pat (
    .cfg_clk, .arst_n, .ctrl, .sync, .pix_x, .pix_y,
    .hs_out, .vs_out, .de_out, .r_out, .g_out, .b_out
  );

endmodule

// File: src/i2c_byte_master.sv
`timescale 1ns/1ps
module i2c_byte_master #(
  parameter int         I2C_DIV  = 25,
  parameter logic [6:0] DEV_ADDR = 7'h59
) (
  input  logic               cfg_clk,
  input  logic               arst_n,
  input  logic               req_valid,
  input  hdmi_pkg::i2c_req_t req,
  input  logic               sda_in,
  output logic               scl,
  output logic               sda_oe,   // 1 pulls sda low
  output logic               done,
  output logic               nack
);

  localparam int DIV_W = (I2C_DIV > 1) ? $clog2(I2C_DIV) : 1;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_ACK,
    S_STOP,
    S_DONE
  } state_e;

  state_e           state;
  logic [DIV_W-1:0] div_cnt;   // cycles per quarter
  logic [1:0]       qtr;       // quarter of the scl bit
  logic [2:0]       bit_cnt;
  logic [1:0]       byte_cnt;  // addr, reg, data
  logic [23:0]      shreg;     // msb goes out first
  logic             nack_q;
  logic             tick;
  logic             bit_end;
  logic             scl_d;
  logic             sda_low_d;

  assign tick    = (div_cnt == DIV_W'(I2C_DIV - 1));
  assign bit_end = tick && (qtr == 2'd3);

  // scl low in quarters 0-1, high in 2-3
  // sda only moves in quarter 1 so it never changes under a high scl
  always_comb
  begin
    scl_d     = 1'b1;
    sda_low_d = 1'b0;
    case (state)
      S_START:
        sda_low_d = qtr[1];  // falls with scl high
      S_DATA:
      begin
        scl_d     = qtr[1];
        sda_low_d = (qtr == 2'd0) ? sda_oe : ~shreg[23];
      end
      S_ACK:
      begin
        scl_d     = qtr[1];
        sda_low_d = (qtr == 2'd0) ? sda_oe : 1'b0;  // released for target
      end
      S_STOP:
      begin
        scl_d     = qtr[1];
        sda_low_d = (qtr == 2'd0) ? sda_oe : (qtr != 2'd3);  // rises last
      end
      default:
      begin
        scl_d     = 1'b1;
        sda_low_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= S_IDLE;
      div_cnt  <= '0;
      qtr      <= 2'd0;
      bit_cnt  <= 3'd0;
      byte_cnt <= 2'd0;
      nack_q   <= 1'b0;
      scl      <= 1'b1;   // bus idle
      sda_oe   <= 1'b0;
    end
    else
    begin
      scl    <= scl_d;
      sda_oe <= sda_low_d;
      if (state == S_IDLE || state == S_DONE)
      begin
        div_cnt <= '0;
        qtr     <= 2'd0;
      end
      else if (tick)
      begin
        div_cnt <= '0;
        qtr     <= qtr + 2'd1;
      end
      else
        div_cnt <= div_cnt + 1'b1;
      case (state)
        S_IDLE:
          if (req_valid)
          begin
            byte_cnt <= 2'd0;
            bit_cnt  <= 3'd0;
            nack_q   <= 1'b0;
            state    <= S_START;
          end
        S_START:
          if (bit_end)
            state <= S_DATA;
        S_DATA:
          if (bit_end)
          begin
            bit_cnt <= bit_cnt + 3'd1;  // wraps to 0 for the next byte
            if (bit_cnt == 3'd7)
              state <= S_ACK;
          end
        S_ACK:
          if (bit_end)  // last cycle of scl high
          begin
            if (sda_in)
            begin
              nack_q <= 1'b1;
              state  <= S_STOP;  // stop right away
            end
            else if (byte_cnt == 2'd2)
              state <= S_STOP;
            else
            begin
              byte_cnt <= byte_cnt + 2'd1;
              state    <= S_DATA;
            end
          end
        S_STOP:
          if (bit_end)
            state <= S_DONE;
        default:
          state <= S_IDLE;  // done lasts one cycle
      endcase
    end
  end

  // payload shifter
  always_ff @(posedge cfg_clk)
  begin
    if (state == S_IDLE && req_valid)
      shreg <= {DEV_ADDR, 1'b0, req.reg_addr, req.data};  // write bit 0
    else if (state == S_DATA && bit_end)
      shreg <= {shreg[22:0], 1'b0};
  end

  assign done = (state == S_DONE);
  assign nack = nack_q;  // valid with done

endmodule

// File: src/pattern_out.sv
`timescale 1ns/1ps
module pattern_out #(
  parameter int H_ACTIVE = 640
) (
  input  logic                        cfg_clk,
  input  logic                        arst_n,
  input  hdmi_pkg::ctrl_t             ctrl,
  input  hdmi_pkg::vid_sync_t         sync,
  input  logic [hdmi_pkg::PIX_W-1:0]  pix_x,
  input  logic [hdmi_pkg::PIX_W-1:0]  pix_y,
  output logic                        hs_out,
  output logic                        vs_out,
  output logic                        de_out,
  output logic [7:0]                  r_out,
  output logic [7:0]                  g_out,
  output logic [7:0]                  b_out
);

  logic [15:0] rgb565;   // r[15:11] g[10:5] b[4:0]
  logic [2:0]  bar_idx;

  // eight equal bars across the active width
  assign bar_idx = 3'(({3'b000, pix_x} << 3) / H_ACTIVE);

  always_comb
  begin
    case (ctrl.pattern)
      hdmi_pkg::PAT_BARS:  rgb565 = hdmi_pkg::BAR_COLORS[bar_idx];
      hdmi_pkg::PAT_WHITE: rgb565 = 16'hffff;
      hdmi_pkg::PAT_BLACK: rgb565 = 16'h0000;
      default:             rgb565 = {pix_x[4:0], pix_y[5:0], 5'b00000};  // ramp
    endcase
  end

  // one stage, pixel and syncs together
  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hs_out <= 1'b0;
      vs_out <= 1'b0;
      de_out <= 1'b0;
      r_out  <= 8'd0;
      g_out  <= 8'd0;
      b_out  <= 8'd0;
    end
    else
    begin
      hs_out <= sync.hs;
      vs_out <= sync.vs;
      de_out <= sync.de;
      if (sync.de)
      begin
        r_out <= {rgb565[15:11], 3'b000};  // 565 to 888, zero fill
        g_out <= {rgb565[10:5], 2'b00};
        b_out <= {rgb565[4:0], 3'b000};
      end
      else
      begin
        r_out <= 8'd0;  // black in blanking
        g_out <= 8'd0;
        b_out <= 8'd0;
      end
    end
  end

endmodule

// File: src/tx_init_seq.sv
`timescale 1ns/1ps
module tx_init_seq (
  input  logic                cfg_clk,
  input  logic                arst_n,
  input  hdmi_pkg::ctrl_t     ctrl,
  input  logic                done,
  input  logic                nack,
  output logic                req_valid,
  output hdmi_pkg::i2c_req_t  req,
  output hdmi_pkg::status_t   status,
  output logic                video_on
);

  localparam int IDX_W = $clog2(hdmi_pkg::INIT_LEN);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,   // latch table entry
    WAIT,    // write in flight
    FINISH
  } state_e;

  state_e           state;
  logic [IDX_W-1:0] idx;      // current table entry
  logic             busy_q;
  logic             over_q;
  logic             nack_q;

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state  <= IDLE;
      idx    <= '0;
      busy_q <= 1'b0;
      over_q <= 1'b0;
      nack_q <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (ctrl.init_start)  // starts only from idle, ignored while busy
          begin
            busy_q <= 1'b1;
            over_q <= 1'b0;
            nack_q <= 1'b0;
            idx    <= '0;
            state  <= ISSUE;
          end
        ISSUE:
          state <= WAIT;
        WAIT:
          if (done)
          begin
            if (nack)
            begin
              nack_q <= 1'b1;  // abort at this entry
              busy_q <= 1'b0;
              state  <= IDLE;
            end
            else if (idx == IDX_W'(hdmi_pkg::INIT_LEN - 1))
              state <= FINISH;
            else
            begin
              idx   <= idx + 1'b1;
              state <= ISSUE;
            end
          end
        FINISH:
        begin
          busy_q <= 1'b0;  // same edge as over
          over_q <= 1'b1;
          state  <= IDLE;
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // request payload, held through WAIT
  always_ff @(posedge cfg_clk)
  begin
    if (state == ISSUE)
      req <= hdmi_pkg::INIT_TABLE[idx];
  end

  assign req_valid = (state == WAIT);
  assign status    = '{nack_err: nack_q, init_over: over_q, init_busy: busy_q};
  assign video_on  = over_q & ctrl.video_en;  // video only after a clean init

endmodule

// File: src/video_timing.sv
`timescale 1ns/1ps
module video_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                         cfg_clk,
  input  logic                         arst_n,
  input  logic                         video_on,
  output hdmi_pkg::vid_sync_t          sync,
  output logic [hdmi_pkg::PIX_W-1:0]   pix_x,
  output logic [hdmi_pkg::PIX_W-1:0]   pix_y
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_W     = $clog2(H_TOTAL);
  localparam int V_W     = $clog2(V_TOTAL);

  logic [H_W-1:0] h_cnt;  // active, front, sync, back
  logic [V_W-1:0] v_cnt;
  logic           h_act;
  logic           v_act;

  always_ff @(posedge cfg_clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (!video_on)
    begin
      h_cnt <= '0;  // parked at frame start
      v_cnt <= '0;
    end
    else if (h_cnt == H_W'(H_TOTAL - 1))
    begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end
    else
      h_cnt <= h_cnt + 1'b1;
  end

  assign h_act = (h_cnt < H_W'(H_ACTIVE));
  assign v_act = (v_cnt < V_W'(V_ACTIVE));

  // active high syncs, all low while off
  assign sync.hs = video_on && (h_cnt >= H_W'(H_ACTIVE + H_FRONT))
                 && (h_cnt < H_W'(H_ACTIVE + H_FRONT + H_SYNC));
  assign sync.vs = video_on && (v_cnt >= V_W'(V_ACTIVE + V_FRONT))
                 && (v_cnt < V_W'(V_ACTIVE + V_FRONT + V_SYNC));
  assign sync.de = video_on && h_act && v_act;

  assign pix_x = sync.de ? hdmi_pkg::PIX_W'(h_cnt) : '0;  // zero outside active
  assign pix_y = sync.de ? hdmi_pkg::PIX_W'(v_cnt) : '0;

endmodule
